// File: filelist.f
+incdir+hw
hw/cop_isa_pkg.sv
hw/cop_pipe_pkg.sv
hw/cop_queue.sv
hw/cop_issue_decode.sv
hw/palu_adder.sv
hw/palu_shifter.sv
hw/palu.sv
hw/cop_execute.sv
hw/cop_top.sv
test/cop_asserts.sv
test/cop_tb.sv

// File: Bender.yml
package:
  name: cop_slice

sources:
  - include_dirs:
      - hw
    files:
      - hw/cop_isa_pkg.sv
      - hw/cop_pipe_pkg.sv
      - hw/cop_queue.sv
      - hw/cop_issue_decode.sv
      - hw/palu_adder.sv
      - hw/palu_shifter.sv
      - hw/palu.sv
      - hw/cop_execute.sv
      - hw/cop_top.sv
  - target: test
    files:
      - test/cop_asserts.sv
      - test/cop_tb.sv

// File: test/cop_tb.sv
// Testbench for the coprocessor slice
// Issues a table of instruction words back to back and checks every
// writeback record in issue order under random result back-pressure

`timescale 1ns/1ps
`default_nettype none

module cop_tb;

    import cop_isa_pkg::*;

    localparam iclass_t CL_MV = ICLASS_MOVE;
    localparam iclass_t CL_BW = ICLASS_BITWISE;
    localparam iclass_t CL_PA = ICLASS_PACKED_ARITH;
    localparam iclass_t CL_TW = ICLASS_TWIDDLE;

    typedef struct {
        logic [31:0] instr;
        logic [31:0] gpr;
        logic [3:0]  rd;     // Expected writeback fields
        logic [3:0]  ben;
        logic [31:0] data;
    } entry_t;

    logic        g_clk, rst_n, issue_valid, issue_ready, res_valid, res_ready;
    logic [31:0] issue_instr, issue_gpr, res_data;
    logic [3:0]  res_rd, res_ben;
    entry_t      table_q [$];

    cop_top uut (
        .g_clk (g_clk), .rst_n (rst_n),
        .issue_valid (issue_valid), .issue_ready (issue_ready),
        .issue_instr (issue_instr), .issue_gpr (issue_gpr),
        .res_valid (res_valid), .res_ready (res_ready),
        .res_rd (res_rd), .res_ben (res_ben), .res_data (res_data)
    );

    bind cop_top cop_asserts u_asserts (
        .g_clk (g_clk), .rst_n (rst_n), .issue_ready (issue_ready),
        .res_valid (res_valid), .res_ready (res_ready),
        .res_ben (res_ben), .res_data (res_data)
    );

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;   // 100 ns period
    end

    // --------------------------------------------------
    // Instruction word, imm lands in 9:0 or over rs1/rs2 for 16-bit loads
    function automatic logic [31:0] encode(iclass_t cls, sclass_t sub, pw_t pw,
                                           logic [3:0] rd, logic [3:0] rs1,
                                           logic [3:0] rs2, logic [15:0] imm);
        return {cls, sub, pw, rd, rs1, rs2, 10'd0} | {16'd0, imm};
    endfunction

    task automatic push_entry(logic [31:0] instr, logic [31:0] gpr, logic [3:0] rd,
                              logic [3:0] ben, logic [31:0] data);
        entry_t e;
        e = '{instr: instr, gpr: gpr, rd: rd, ben: ben, data: data};
        table_q.push_back(e);
    endtask

    task automatic add_row(iclass_t cls, sclass_t sub, pw_t pw, logic [3:0] rd,
                           logic [3:0] rs1, logic [3:0] rs2, logic [15:0] imm,
                           logic [3:0] ben, logic [31:0] data);
        push_entry(encode(cls, sub, pw, rd, rs1, rs2, imm), 32'd0, rd, ben, data);
    endtask

    // GPR move always writes the host value
    task automatic load_gpr(logic [3:0] rd, logic [31:0] gpr);
        push_entry(encode(CL_MV, SCLASS_GPR2XCR, PW_32, rd, 0, 0, 0), gpr, rd, 4'hF, gpr);
    endtask

    task automatic build_table();
        load_gpr(1, 32'h1234_5678);
        load_gpr(2, 32'h0F0F_F0F0);
        add_row(CL_BW, SCLASS_LD_LI, PW_32, 3, 0, 0, 16'hBEEF, 4'hF, 32'h0000_BEEF);
        add_row(CL_BW, SCLASS_LD_HI, PW_32, 3, 0, 0, 16'hDEAD, 4'hF, 32'hDEAD_BEEF);
        add_row(CL_MV, SCLASS_CMOV,  PW_32, 4, 1, 0, 0, 4'hF, 32'h1234_5678);
        add_row(CL_MV, SCLASS_CMOV,  PW_32, 5, 1, 2, 0, 4'h0, 32'h1234_5678);
        add_row(CL_MV, SCLASS_CMOVN, PW_32, 5, 3, 0, 0, 4'h0, 32'hDEAD_BEEF);
        add_row(CL_MV, SCLASS_CMOVN, PW_32, 6, 3, 2, 0, 4'hF, 32'hDEAD_BEEF);
        load_gpr(9,  32'hFFFF_FFFF);
        load_gpr(10, 32'h5555_5555);
        load_gpr(11, 32'h0000_0001);
        load_gpr(13, 32'h0000_0024);   // Shift amount 4
        // Lane-wise add and subtract, c5 still zero after the skipped moves
        add_row(CL_PA, SCLASS_ADD_PX, PW_32, 8,  5,  1,  0, 4'hF, 32'h1234_5678);
        add_row(CL_PA, SCLASS_ADD_PX, PW_32, 12, 9,  10, 0, 4'hF, 32'h5555_5554);
        add_row(CL_PA, SCLASS_ADD_PX, PW_16, 12, 9,  10, 0, 4'hF, 32'h5554_5554);
        add_row(CL_PA, SCLASS_ADD_PX, PW_8,  12, 9,  10, 0, 4'hF, 32'h5454_5454);
        add_row(CL_PA, SCLASS_ADD_PX, PW_4,  12, 9,  10, 0, 4'hF, 32'h4444_4444);
        add_row(CL_PA, SCLASS_ADD_PX, PW_2,  12, 9,  10, 0, 4'hF, 32'h0000_0000);
        add_row(CL_PA, SCLASS_ADD_PX, PW_16, 12, 9,  11, 0, 4'hF, 32'hFFFF_0000);
        add_row(CL_PA, SCLASS_ADD_PX, PW_2,  12, 9,  11, 0, 4'hF, 32'hFFFF_FFFC);
        add_row(CL_PA, SCLASS_ADD_PX, 3'd7,  12, 9,  10, 0, 4'hF, 32'h5555_5554);
        add_row(CL_PA, SCLASS_SUB_PX, PW_32, 12, 10, 9,  0, 4'hF, 32'h5555_5556);
        add_row(CL_PA, SCLASS_SUB_PX, PW_16, 12, 10, 9,  0, 4'hF, 32'h5556_5556);
        add_row(CL_PA, SCLASS_SUB_PX, PW_8,  12, 10, 9,  0, 4'hF, 32'h5656_5656);
        add_row(CL_PA, SCLASS_SUB_PX, PW_4,  12, 10, 9,  0, 4'hF, 32'h6666_6666);
        add_row(CL_PA, SCLASS_SUB_PX, PW_2,  12, 10, 9,  0, 4'hF, 32'hAAAA_AAAA);
        // Shifts and rotates of c1
        add_row(CL_PA, SCLASS_SLL_PX,  PW_32, 14, 1, 11, 0, 4'hF, 32'h2468_ACF0);
        add_row(CL_PA, SCLASS_SLL_PX,  PW_2,  14, 1, 11, 0, 4'hF, 32'h2028_A8A0);
        add_row(CL_PA, SCLASS_SRL_PX,  PW_8,  14, 1, 13, 0, 4'hF, 32'h0103_0507);
        add_row(CL_PA, SCLASS_ROT_PX,  PW_16, 14, 1, 13, 0, 4'hF, 32'h4123_8567);
        add_row(CL_PA, SCLASS_SLLI_PX, PW_4,  14, 1, 0, 'd5, 4'hF, 32'h2468_ACE0);
        add_row(CL_PA, SCLASS_SRLI_PX, PW_16, 14, 1, 0, 'd3, 4'hF, 32'h0246_0ACF);
        add_row(CL_PA, SCLASS_ROTI_PX, PW_8,  14, 1, 0, 'd9, 4'hF, 32'h091A_2B3C);
        add_row(CL_PA, SCLASS_ROTI_PX, PW_32, 14, 1, 0, 'd8, 4'hF, 32'h7812_3456);
        add_row(CL_PA, SCLASS_ROTI_PX, PW_2,  14, 1, 0, 'd1, 4'hF, 32'h2138_A9B4);
        // Bitwise group
        add_row(CL_BW, SCLASS_BOP,   PW_32, 14, 1, 2, 'h6,  4'hF, 32'h1D3B_A688);  // XOR
        add_row(CL_BW, SCLASS_BOP,   PW_32, 14, 1, 2, 'h8,  4'hF, 32'h0204_5070);  // AND
        add_row(CL_BW, SCLASS_EXT,   PW_32, 14, 1, 0, 'h24, 4'hF, 32'h0000_0067);
        add_row(CL_BW, SCLASS_EXT,   PW_32, 14, 1, 0, 'h3A, 4'hF, 32'h0008_D159);
        add_row(CL_BW, SCLASS_INS,   PW_32, 6,  1, 0, 'h44, 4'hF, 32'hDEAD_78EF);
        add_row(CL_BW, SCLASS_MIX_L, PW_32, 3,  1, 2, 'h4,  4'hF, 32'hD1A3_4E6F);
        add_row(CL_BW, SCLASS_MIX_H, PW_32, 15, 1, 2, 'h0,  4'hF, 32'h0608_1030);
        // Twiddles of c1
        add_row(CL_TW, SCLASS_TWID_B,  PW_32, 14, 1, 0, 'hE4, 4'hF, 32'h7856_3412);
        add_row(CL_TW, SCLASS_TWID_N0, PW_32, 14, 1, 0, 'hE4, 4'hF, 32'h1234_8765);
        add_row(CL_TW, SCLASS_TWID_N1, PW_32, 14, 1, 0, 'h00, 4'hF, 32'h4444_5678);
        add_row(CL_TW, SCLASS_TWID_C1, PW_32, 14, 1, 0, 'hE4, 4'hF, 32'h1234_9578);
        add_row(CL_TW, SCLASS_TWID_C3, PW_32, 14, 1, 0, 'hAA, 4'hF, 32'h5534_5678);
        // Illegal classes write nothing, c12 keeps the last subtract
        add_row(3'd0, 4'd0, PW_32, 12, 1, 2, 0, 4'h0, 32'h0000_0000);
        add_row(3'd6, 4'd1, PW_32, 12, 1, 2, 0, 4'h0, 32'h0000_0000);
        add_row(CL_MV, SCLASS_CMOV, PW_32, 7, 12, 0, 0, 4'hF, 32'hAAAA_AAAA);
    endtask

    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "stopped on first mismatch");
        end
    endtask

    // Hold the word until the decoder takes it
    task automatic issue_one(entry_t e);
        logic taken;
        issue_valid = 1'b1;
        issue_instr = e.instr;
        issue_gpr   = e.gpr;
        taken       = 1'b0;
        while (!taken) begin
            @(negedge g_clk);
            taken = issue_ready;   // Settled mid-cycle
            @(posedge g_clk);
            #1;
        end
    endtask

    // --------------------------------------------------
    initial begin
        issue_valid = 1'b0;
        issue_instr = '0;
        issue_gpr   = '0;
        res_ready   = 1'b0;
        rst_n       = 1'b0;
        build_table();
        repeat (3) @(posedge g_clk);
        #1 rst_n = 1'b1;
        foreach (table_q[i]) begin
            issue_one(table_q[i]);   // Back to back
        end
        issue_valid = 1'b0;
    end

    // Result collector with random ready
    initial begin
        int unsigned idx;
        void'($urandom(80784));
        wait (rst_n === 1'b1);
        check_value("res_valid after reset", {31'd0, res_valid}, 32'd0);
        idx = 0;
        while (idx < table_q.size()) begin
            @(posedge g_clk);
            #1 res_ready = (($urandom % 4) != 0);   // About 3 in 4
            @(negedge g_clk);
            if (res_valid && res_ready) begin
                check_value($sformatf("entry %0d rd", idx), res_rd, table_q[idx].rd);
                check_value($sformatf("entry %0d ben", idx), res_ben, table_q[idx].ben);
                check_value($sformatf("entry %0d data", idx), res_data, table_q[idx].data);
                idx++;
            end
        end
        @(posedge g_clk);
        #1 res_ready = 1'b1;
        repeat (4) @(negedge g_clk);
        check_value("res_valid after last entry", {31'd0, res_valid}, 32'd0);   // No extras
        if (uut.u_asserts.fail_cnt == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("assertion failures seen: %0d", uut.u_asserts.fail_cnt);
            $display("*** FAILED ***");
            $fatal(1, "bound assertions failed");
        end
    end

    // Watchdog, 20 cycles per entry plus reset
    initial begin
        #1;
        repeat (table_q.size() * 20 + 3) @(posedge g_clk);
        $display("timeout at %0t ns: not every result came back", $time);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: test/cop_asserts.sv
// Coprocessor top-level handshake assertions
// Bound to cop_top, counts every failure for the testbench

`timescale 1ns/1ps
`default_nettype none

module cop_asserts (
    input logic        g_clk,
    input logic        rst_n,
    input logic        issue_ready,
    input logic        res_valid,
    input logic        res_ready,
    input logic [3:0]  res_ben,
    input logic [31:0] res_data
);

    int unsigned fail_cnt = 0;   // Read at end of run

    // Stalled result holds still
    a_res_hold: assert property (@(posedge g_clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && $stable(res_data))
        else begin
            fail_cnt++;
            $error("result changed while res_ready was low");
        end

    // No issue handshake inside reset
    a_rst_ready: assert property (@(posedge g_clk) !rst_n |-> !issue_ready)
        else begin
            fail_cnt++;
            $error("issue_ready high during reset");
        end

    a_ben_legal: assert property (@(posedge g_clk) disable iff (!rst_n)
        res_valid |-> (res_ben == 4'h0 || res_ben == 4'hF))
        else begin
            fail_cnt++;
            $error("res_ben neither 0 nor F");
        end

endmodule

`default_nettype wire

// File: hw/cop_top.sv
// Coprocessor slice top level
// Issue decoder, instruction queue, execute unit and result queue in a chain

`timescale 1ns/1ps
`default_nettype none
`include "cop_settings.svh"

module cop_top (
    input  logic                  g_clk,
    input  logic                  rst_n,
    input  logic                  issue_valid,
    output logic                  issue_ready,
    input  logic [31:0]           issue_instr,
    input  logic [31:0]           issue_gpr,
    output logic                  res_valid,
    input  logic                  res_ready,
    output cop_isa_pkg::cpr_idx_t res_rd,
    output logic [3:0]            res_ben,
    output logic [31:0]           res_data
);

    import cop_pipe_pkg::*;

    dec_instr_t dec_rec, ex_rec;
    wb_rec_t    wb_rec, res_rec;
    logic       dec_valid, dec_full, ex_empty, ex_pop;
    logic       wb_valid, wb_full, res_empty;

    cop_issue_decode u_decode (
        .g_clk       (g_clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_instr (issue_instr),
        .issue_gpr   (issue_gpr),
        .dec_valid   (dec_valid),
        .dec_rec     (dec_rec),
        .dec_ready   (!dec_full)
    );

    // Instruction queue
    cop_queue #(.payload_t(dec_instr_t), .DEPTH(`COP_ISSUE_DEPTH)) u_iq (
        .g_clk (g_clk), .rst_n (rst_n),
        .push  (dec_valid), .push_data (dec_rec), .full  (dec_full),
        .pop   (ex_pop),    .pop_data  (ex_rec),  .empty (ex_empty)
    );

    cop_execute u_execute (
        .g_clk    (g_clk),
        .rst_n    (rst_n),
        .ex_valid (!ex_empty),
        .ex_rec   (ex_rec),
        .ex_pop   (ex_pop),
        .wb_valid (wb_valid),
        .wb_rec   (wb_rec),
        .wb_ready (!wb_full)
    );

    // Result queue, drained by the host
    cop_queue #(.payload_t(wb_rec_t), .DEPTH(`COP_RESULT_DEPTH)) u_rq (
        .g_clk (g_clk), .rst_n (rst_n),
        .push  (wb_valid),  .push_data (wb_rec),  .full  (wb_full),
        .pop   (res_ready), .pop_data  (res_rec), .empty (res_empty)
    );

    assign res_valid = !res_empty;
    assign res_rd    = res_rec.rd;
    assign res_ben   = res_rec.ben;
    assign res_data  = res_rec.data;

endmodule

`default_nettype wire

// File: hw/cop_execute.sv
// Coprocessor execute unit
// Owns the register file, runs one decoded record per cycle through
// the packed ALU and pushes its writeback record

`timescale 1ns/1ps
`default_nettype none
`include "cop_settings.svh"

module cop_execute (
    input  logic                     g_clk,
    input  logic                     rst_n,
    input  logic                     ex_valid,
    input  cop_pipe_pkg::dec_instr_t ex_rec,
    output logic                     ex_pop,
    output logic                     wb_valid,
    output cop_pipe_pkg::wb_rec_t    wb_rec,
    input  logic                     wb_ready
);

    logic [31:0] cpr [`COP_NUM_CPR];   // Coprocessor registers
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] rs3_val;
    logic [31:0] alu_wdata;
    logic [3:0]  alu_ben;

    // Fires only when both queues allow it
    assign ex_pop   = ex_valid && wb_ready;
    assign wb_valid = ex_valid;   // Held with the queue head

    assign rs1_val = cpr[ex_rec.rs1];
    assign rs2_val = cpr[ex_rec.rs2];
    assign rs3_val = cpr[ex_rec.rd];   // crd on the third source

    palu u_palu (
        .valid    (ex_valid),
        .gpr_rs1  (ex_rec.gpr),
        .rs1      (rs1_val),
        .rs2      (rs2_val),
        .rs3      (rs3_val),
        .imm      (ex_rec.imm),
        .pw       (ex_rec.pw),
        .iclass   (ex_rec.iclass),
        .subclass (ex_rec.subclass),
        .rd_ben   (alu_ben),
        .rd_wdata (alu_wdata)
    );

    assign wb_rec = '{rd: ex_rec.rd, ben: alu_ben, data: alu_wdata};

    // Byte-enabled write, visible to the next record
    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `COP_NUM_CPR; i++) begin
                cpr[i] <= '0;
            end
        end else if (ex_pop) begin
            for (int b = 0; b < 4; b++) begin
                if (alu_ben[b]) begin
                    cpr[ex_rec.rd][8*b +: 8] <= alu_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/palu.sv
// Packed ALU
// Combinational move, bitwise, twiddle and packed arithmetic unit,
// results merged by an AND-OR mux with per-byte write enables

`timescale 1ns/1ps
`default_nettype none

module palu (
    input  logic                 valid,
    input  logic [31:0]          gpr_rs1,
    input  logic [31:0]          rs1,
    input  logic [31:0]          rs2,
    input  logic [31:0]          rs3,       // Always crd
    input  logic [15:0]          imm,
    input  cop_isa_pkg::pw_t     pw,
    input  cop_isa_pkg::iclass_t iclass,
    input  cop_isa_pkg::sclass_t subclass,
    output logic [3:0]           rd_ben,
    output logic [31:0]          rd_wdata
);

    import cop_isa_pkg::*;

    logic is_mov, is_bw, is_pa, is_tw;
    logic is_gpr2xcr, is_cmov, is_cmovn, wen_mov;
    logic bw_bop, bw_ext, bw_ins, bw_mix_l, bw_mix_h, bw_li, bw_hi;
    logic pa_add, pa_sub, pa_sll, pa_srl, pa_rot, pa_slli, pa_srli, pa_roti, pa_shift;
    logic tw_b, tw_n0, tw_n1;
    logic [3:0]  tw_csel;             // Byte picked by twid.cX
    logic [4:0]  ei_start, ei_len, mix_amt, shf_amt;
    logic [31:0] bop_res, ei_mask, ext_res, ins_res, mix_res;
    logic [63:0] mix_dbl;
    logic [31:0] add_c, shf_c;
    logic [15:0] tw_hw;
    logic [7:0]  tw_cb;
    logic [31:0] tw_b_out, tw_c_res;
    logic [15:0] tw_n_out;
    logic [7:0]  tw_c_out;
    logic [31:0] res_mov, res_bw, res_pa, res_tw;

    // Class decode, nothing is selected without valid
    assign is_mov = valid && iclass == ICLASS_MOVE;
    assign is_bw  = valid && iclass == ICLASS_BITWISE;
    assign is_pa  = valid && iclass == ICLASS_PACKED_ARITH;
    assign is_tw  = valid && iclass == ICLASS_TWIDDLE;

    // --------------------------------------------------
    // Moves
    assign is_gpr2xcr = is_mov && subclass == SCLASS_GPR2XCR;
    assign is_cmov    = is_mov && subclass == SCLASS_CMOV;
    assign is_cmovn   = is_mov && subclass == SCLASS_CMOVN;
    assign res_mov    = is_gpr2xcr ? gpr_rs1 : rs1;
    assign wen_mov    = is_gpr2xcr || (is_cmov && rs2 == '0) || (is_cmovn && rs2 != '0);

    // --------------------------------------------------
    // Bitwise
    assign bw_bop   = is_bw && subclass == SCLASS_BOP;
    assign bw_ext   = is_bw && subclass == SCLASS_EXT;
    assign bw_ins   = is_bw && subclass == SCLASS_INS;
    assign bw_mix_l = is_bw && subclass == SCLASS_MIX_L;
    assign bw_mix_h = is_bw && subclass == SCLASS_MIX_H;
    assign bw_li    = is_bw && subclass == SCLASS_LD_LI;
    assign bw_hi    = is_bw && subclass == SCLASS_LD_HI;

    for (genvar i = 0; i < 32; i++) begin : g_bop
        assign bop_res[i] = imm[{rs1[i], rs2[i]}];   // Truth table lookup
    end

    assign ei_start = {imm[7:4], 1'b0};   // Nibbles doubled
    assign ei_len   = {imm[3:0], 1'b0};
    assign ei_mask  = ~(32'hFFFF_FFFF << ei_len);
    assign ext_res  = (rs1 >> ei_start) & ei_mask;
    assign ins_res  = ((rs1 & ei_mask) << ei_start) | (rs3 & ~(ei_mask << ei_start));

    assign mix_amt = {bw_mix_h, imm[3:0]};    // High form rotates 16 more
    assign mix_dbl = {rs1, rs1} >> mix_amt;   // Lower word is rotr
    assign mix_res = (rs2 & mix_dbl[31:0]) | (~rs2 & rs3);

    assign res_bw = {32{bw_li}}             & {rs3[31:16], imm} |
                    {32{bw_hi}}             & {imm, rs3[15:0]}  |
                    {32{bw_bop}}            & bop_res           |
                    {32{bw_ext}}            & ext_res           |
                    {32{bw_ins}}            & ins_res           |
                    {32{bw_mix_l|bw_mix_h}} & mix_res;

    // --------------------------------------------------
    // Twiddle, select pairs read from imm, imm[1:0] feeds the top slot
    assign tw_b    = is_tw && subclass == SCLASS_TWID_B;
    assign tw_n0   = is_tw && subclass == SCLASS_TWID_N0;
    assign tw_n1   = is_tw && subclass == SCLASS_TWID_N1;
    assign tw_csel = {is_tw && subclass == SCLASS_TWID_C3, is_tw && subclass == SCLASS_TWID_C2,
                      is_tw && subclass == SCLASS_TWID_C1, is_tw && subclass == SCLASS_TWID_C0};
    assign tw_hw   = tw_n0 ? rs1[15:0] : rs1[31:16];

    always_comb begin
        tw_cb = '0;
        for (int p = 0; p < 4; p++) begin
            tw_cb |= {8{tw_csel[p]}} & rs1[8*p +: 8];
        end
    end

    for (genvar p = 0; p < 4; p++) begin : g_twid
        assign tw_b_out[8*p +: 8] = rs1[8*imm[2*(3-p) +: 2] +: 8];
        assign tw_n_out[4*p +: 4] = tw_hw[4*imm[2*(3-p) +: 2] +: 4];
        assign tw_c_out[2*p +: 2] = tw_cb[2*imm[2*(3-p) +: 2] +: 2];
        assign tw_c_res[8*p +: 8] = tw_csel[p] ? tw_c_out : rs1[8*p +: 8];
    end

    assign res_tw = {32{tw_b}}     & tw_b_out                |
                    {32{tw_n0}}    & {rs1[31:16], tw_n_out}  |
                    {32{tw_n1}}    & {tw_n_out, rs1[15:0]}   |
                    {32{|tw_csel}} & tw_c_res;

    // --------------------------------------------------
    // Packed arithmetic
    assign pa_add   = is_pa && subclass == SCLASS_ADD_PX;
    assign pa_sub   = is_pa && subclass == SCLASS_SUB_PX;
    assign pa_sll   = is_pa && subclass == SCLASS_SLL_PX;
    assign pa_srl   = is_pa && subclass == SCLASS_SRL_PX;
    assign pa_rot   = is_pa && subclass == SCLASS_ROT_PX;
    assign pa_slli  = is_pa && subclass == SCLASS_SLLI_PX;
    assign pa_srli  = is_pa && subclass == SCLASS_SRLI_PX;
    assign pa_roti  = is_pa && subclass == SCLASS_ROTI_PX;
    assign pa_shift = pa_sll | pa_srl | pa_rot | pa_slli | pa_srli | pa_roti;
    assign shf_amt  = (pa_slli | pa_srli | pa_roti) ? imm[4:0] : rs2[4:0];

    palu_adder u_adder (.a(rs1), .b(rs2), .pw(pw), .sub(pa_sub), .c(add_c));

    palu_shifter u_shifter (
        .a     (rs1),
        .shamt (shf_amt),
        .pw    (pw),
        .sl    (pa_sll | pa_slli),
        .r     (pa_rot | pa_roti),
        .c     (shf_c)
    );

    assign res_pa = {32{pa_add | pa_sub}} & add_c | {32{pa_shift}} & shf_c;

    // Result merge and write enables
    assign rd_wdata = {32{is_mov}} & res_mov | {32{is_bw}} & res_bw |
                      {32{is_pa}}  & res_pa  | {32{is_tw}} & res_tw;
    assign rd_ben   = is_mov                   ? {4{wen_mov}} :
                      (is_bw || is_pa || is_tw) ? 4'hF         : 4'h0;  // Illegal class

endmodule

`default_nettype wire

// File: hw/palu_shifter.sv
// Packed-lane logical shifter and rotator
// Every lane shifts on its own by the amount modulo the lane width

`timescale 1ns/1ps
`default_nettype none

module palu_shifter (
    input  logic [31:0]      a,
    input  logic [4:0]       shamt,
    input  cop_isa_pkg::pw_t pw,
    input  logic             sl,   // Left, else right
    input  logic             r,    // Rotate, else logical shift
    output logic [31:0]      c
);

    import cop_isa_pkg::*;

    logic [4:0][31:0] lane_res;   // One full result per lane width

    for (genvar k = 0; k < 5; k++) begin : g_width
        localparam int W  = 32 >> k;
        localparam int AW = $clog2(W);
        for (genvar l = 0; l < 32 / W; l++) begin : g_lane
            logic [W-1:0]   x;
            logic [AW-1:0]  amt;
            logic [2*W-1:0] dbl_l;   // Upper half is rotl, lower is shl
            logic [2*W-1:0] dbl_r;   // Lower half is rotr, upper is shr
            assign x     = a[l*W +: W];
            assign amt   = shamt[AW-1:0];
            assign dbl_l = {x, x} << amt;
            assign dbl_r = {x, x} >> amt;
            assign lane_res[k][l*W +: W] =
                sl ? (r ? dbl_l[2*W-1:W] : dbl_l[W-1:0]) :
                     (r ? dbl_r[W-1:0]   : dbl_r[2*W-1:W]);
        end
    end

    // Pick the width in use
    always_comb begin
        case (pw)
            PW_16:   c = lane_res[1];
            PW_8:    c = lane_res[2];
            PW_4:    c = lane_res[3];
            PW_2:    c = lane_res[4];
            default: c = lane_res[0];
        endcase
    end

endmodule

`default_nettype wire

// File: hw/palu_adder.sv
// Packed-lane adder and subtractor
// Carry chain is cut at every lane boundary of the pack width

`timescale 1ns/1ps
`default_nettype none

module palu_adder (
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    input  cop_isa_pkg::pw_t pw,
    input  logic             sub,
    output logic [31:0]      c
);

    import cop_isa_pkg::*;

    logic [31:0] lane_lsb;   // Set on the low bit of each lane
    logic [31:0] bx;         // b, inverted to subtract
    logic [31:0] cin;
    logic [31:0] cout;

    always_comb begin
        case (pw)
            PW_16:   lane_lsb = 32'h0001_0001;
            PW_8:    lane_lsb = 32'h0101_0101;
            PW_4:    lane_lsb = 32'h1111_1111;
            PW_2:    lane_lsb = 32'h5555_5555;
            default: lane_lsb = 32'h0000_0001;  // Single 32-bit lane
        endcase
    end

    assign bx = sub ? ~b : b;

    // Ripple chain, carry-in re-injected at each lane start
    for (genvar i = 0; i < 32; i++) begin : g_bit
        if (i == 0) begin : g_first
            assign cin[i] = sub;
        end else begin : g_rest
            assign cin[i] = lane_lsb[i] ? sub : cout[i-1];
        end
        assign c[i]    = a[i] ^ bx[i] ^ cin[i];
        assign cout[i] = (a[i] & bx[i]) | (cin[i] & (a[i] ^ bx[i]));
    end

endmodule

`default_nettype wire

// File: hw/cop_issue_decode.sv
// Coprocessor issue decoder
// Splits a host instruction word into a decoded record held in a
// one-entry output register

`timescale 1ns/1ps
`default_nettype none

module cop_issue_decode (
    input  logic                     g_clk,
    input  logic                     rst_n,
    input  logic                     issue_valid,
    output logic                     issue_ready,
    input  logic [31:0]              issue_instr,
    input  logic [31:0]              issue_gpr,
    output logic                     dec_valid,
    output cop_pipe_pkg::dec_instr_t dec_rec,
    input  logic                     dec_ready
);

    import cop_isa_pkg::*;

    iclass_t f_class;
    sclass_t f_sub;
    pw_t     f_pw;
    logic    is_ld_imm;   // LD_LI / LD_HI take a 16-bit immediate
    logic    take;

    assign f_class   = issue_instr[31:29];
    assign f_sub     = issue_instr[28:25];
    assign f_pw      = issue_instr[24:22];
    assign is_ld_imm = (f_class == ICLASS_BITWISE) &&
                       (f_sub == SCLASS_LD_LI || f_sub == SCLASS_LD_HI);

    // Room when empty or being drained, never during reset
    assign issue_ready = rst_n && (!dec_valid || dec_ready);
    assign take        = issue_valid && issue_ready;

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (take) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    // Output register payload
    always_ff @(posedge g_clk) begin
        if (take) begin
            dec_rec.iclass   <= f_class;
            dec_rec.subclass <= f_sub;
            dec_rec.pw       <= (f_pw inside {[PW_32:PW_2]}) ? f_pw : PW_32;
            dec_rec.rd       <= issue_instr[21:18];
            dec_rec.rs1      <= issue_instr[17:14];
            dec_rec.rs2      <= issue_instr[13:10];
            dec_rec.imm      <= is_ld_imm ? issue_instr[15:0] : {6'd0, issue_instr[9:0]};
            dec_rec.gpr      <= issue_gpr;
        end
    end

endmodule

`default_nettype wire

// File: hw/cop_queue.sv
// Show-ahead synchronous FIFO
// Circular buffer with a type-parameterized payload, head always on pop_data

`timescale 1ns/1ps
`default_nettype none
`include "cop_settings.svh"

module cop_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = `COP_ISSUE_DEPTH
) (
    input  logic     g_clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;     // Entries held
    logic             do_push;
    logic             do_pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;   // Dropped when full
    assign do_pop   = pop && !empty;   // Dropped when empty
    assign pop_data = mem[rd_ptr];     // Show-ahead read

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Both at once leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge g_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/cop_pipe_pkg.sv
// Coprocessor pipeline records
// Payloads carried by the instruction and result queues

`default_nettype none

package cop_pipe_pkg;

    // Decoder output, one per accepted instruction word
    typedef struct packed {
        cop_isa_pkg::iclass_t  iclass;
        cop_isa_pkg::sclass_t  subclass;
        cop_isa_pkg::pw_t      pw;    // Always a legal width here
        cop_isa_pkg::cpr_idx_t rd;    // Also read as rs3
        cop_isa_pkg::cpr_idx_t rs1;
        cop_isa_pkg::cpr_idx_t rs2;
        logic [15:0]           imm;   // Zero-extended 10 or 16 bits
        logic [31:0]           gpr;   // Host GPR operand
    } dec_instr_t;

    // Execute output, drained to the host
    typedef struct packed {
        cop_isa_pkg::cpr_idx_t rd;
        logic [3:0]            ben;   // 0 when the write was suppressed
        logic [31:0]           data;
    } wb_rec_t;

endpackage

`default_nettype wire

// File: hw/cop_isa_pkg.sv
// Coprocessor ISA encodings
// Instruction classes, subclasses and pack widths seen by the packed ALU

`default_nettype none

package cop_isa_pkg;

    typedef logic [2:0] iclass_t;   // Instruction class
    typedef logic [3:0] sclass_t;   // Subclass, meaning depends on class
    typedef logic [2:0] pw_t;       // Pack width
    typedef logic [3:0] cpr_idx_t;  // Coprocessor register index

    // Classes, every other value is illegal
    localparam iclass_t ICLASS_PACKED_ARITH = 3'b001;
    localparam iclass_t ICLASS_TWIDDLE      = 3'b010;
    localparam iclass_t ICLASS_MOVE         = 3'b101;
    localparam iclass_t ICLASS_BITWISE      = 3'b111;

    // Move subclasses
    localparam sclass_t SCLASS_GPR2XCR = 4'b0001;
    localparam sclass_t SCLASS_CMOV    = 4'b0010;
    localparam sclass_t SCLASS_CMOVN   = 4'b0011;

    // Bitwise subclasses
    localparam sclass_t SCLASS_BOP   = 4'b0001;
    localparam sclass_t SCLASS_EXT   = 4'b0010;
    localparam sclass_t SCLASS_INS   = 4'b0011;
    localparam sclass_t SCLASS_MIX_L = 4'b0100;
    localparam sclass_t SCLASS_MIX_H = 4'b0101;
    localparam sclass_t SCLASS_LD_LI = 4'b1000;  // 16-bit immediate forms
    localparam sclass_t SCLASS_LD_HI = 4'b1001;

    // Packed arithmetic subclasses
    localparam sclass_t SCLASS_ADD_PX  = 4'b0001;
    localparam sclass_t SCLASS_SUB_PX  = 4'b0010;
    localparam sclass_t SCLASS_SLL_PX  = 4'b0100;
    localparam sclass_t SCLASS_SRL_PX  = 4'b0101;
    localparam sclass_t SCLASS_ROT_PX  = 4'b0110;
    localparam sclass_t SCLASS_SLLI_PX = 4'b0111;
    localparam sclass_t SCLASS_SRLI_PX = 4'b1000;
    localparam sclass_t SCLASS_ROTI_PX = 4'b1001;

    // Twiddle subclasses
    localparam sclass_t SCLASS_TWID_B  = 4'b0001;
    localparam sclass_t SCLASS_TWID_N0 = 4'b0010;
    localparam sclass_t SCLASS_TWID_N1 = 4'b0011;
    localparam sclass_t SCLASS_TWID_C0 = 4'b0100;
    localparam sclass_t SCLASS_TWID_C1 = 4'b0101;
    localparam sclass_t SCLASS_TWID_C2 = 4'b0110;
    localparam sclass_t SCLASS_TWID_C3 = 4'b0111;

    // Pack widths, lane size 32 down to 2 bits
    localparam pw_t PW_32 = 3'd1;
    localparam pw_t PW_16 = 3'd2;
    localparam pw_t PW_8  = 3'd3;
    localparam pw_t PW_4  = 3'd4;
    localparam pw_t PW_2  = 3'd5;

endpackage

`default_nettype wire

// File: hw/cop_settings.svh
// Coprocessor slice build settings
// Queue depths and register file size

`ifndef COP_SETTINGS_SVH
`define COP_SETTINGS_SVH

`define COP_ISSUE_DEPTH  4   // Decoded instruction queue entries
`define COP_RESULT_DEPTH 4   // Writeback result queue entries
`define COP_NUM_CPR      16  // Coprocessor registers, matches 4-bit index

`endif
